// ==== icache_wrapper.f ====
src/icache_pkg.sv
src/mem_pkg.sv
src/fetch_queue.sv
src/icache.sv
src/icache_miss_engine.sv
src/icache_wrapper.sv
test/icache_checker.sv
test/tb_icache_wrapper.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the icache testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
  --top-module tb_icache_wrapper \
  -f icache_wrapper.f \
  --Mdir obj_dir -o sim_icache
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/sim_icache)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "=== PASS ==="; then
  exit 0
else
  echo "Simulation did not pass"
  exit 1
fi

// ==== test/tb_icache_wrapper.sv ====
`timescale 1ns/1ps

module tb_icache_wrapper
  import icache_pkg::*;
  import mem_pkg::*;
  ();

  localparam int          queue_els_lp    = 8;
  localparam int          timeout_lp      = 2000;
  localparam logic [31:0] mem_pattern_lp  = 32'h5A5A0000;
  localparam logic [1:0]  ready_low_lp    = 2'd0;
  localparam logic [1:0]  ready_high_lp   = 2'd1;
  localparam logic [1:0]  ready_random_lp = 2'd2;

  logic                        clk_i = 1'b0;
  logic                        reset_i;
  fetch_req_s                  fetch_req_i;
  logic                        fetch_v_i;
  logic                        fetch_ready_o;
  instr_t                      data_o;
  logic                        data_v_o;
  mem_header_s                 mem_cmd_header_o;
  logic                        mem_cmd_v_o;
  logic                        mem_cmd_ready_and_i = 1'b1;
  mem_header_s                 mem_resp_header_i   = '0;
  logic [mem_data_width_c-1:0] mem_resp_data_i     = '0;
  logic                        mem_resp_v_i        = 1'b0;
  logic                        mem_resp_ready_and_o;
  logic                        mem_resp_last_i     = 1'b0;

  logic [1:0]  ready_mode;
  logic        ready_next    = 1'b1;
  logic        cmd_taken     = 1'b0;
  mem_header_s cmd_taken_hdr = '0;
  logic        beat_taken    = 1'b0;
  logic        resp_busy     = 1'b0;
  mem_header_s resp_hdr      = '0;
  int          resp_delay    = 0;
  int          resp_beat     = 0;
  int          resp_beats    = 0;
  logic [31:0] beat_addr;
  int          stall_errors  = 0;
  int          check_errors, check_instrs, check_cmds, check_pending;

  always #50 clk_i = ~clk_i;

  icache_wrapper #(.fetch_queue_els_p(queue_els_lp)) UUT
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.fetch_req_i(fetch_req_i)
     ,.fetch_v_i(fetch_v_i)
     ,.fetch_ready_o(fetch_ready_o)
     ,.data_o(data_o)
     ,.data_v_o(data_v_o)
     ,.mem_cmd_header_o(mem_cmd_header_o)
     ,.mem_cmd_v_o(mem_cmd_v_o)
     ,.mem_cmd_ready_and_i(mem_cmd_ready_and_i)
     ,.mem_resp_header_i(mem_resp_header_i)
     ,.mem_resp_data_i(mem_resp_data_i)
     ,.mem_resp_v_i(mem_resp_v_i)
     ,.mem_resp_ready_and_o(mem_resp_ready_and_o)
     ,.mem_resp_last_i(mem_resp_last_i)
     );

  icache_checker #(.pattern_p(mem_pattern_lp)) scoreboard
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.fetch_req_i(fetch_req_i)
     ,.fetch_v_i(fetch_v_i)
     ,.fetch_ready_i(fetch_ready_o)
     ,.data_i(data_o)
     ,.data_v_i(data_v_o)
     ,.mem_cmd_header_i(mem_cmd_header_o)
     ,.mem_cmd_v_i(mem_cmd_v_o)
     ,.mem_cmd_ready_and_i(mem_cmd_ready_and_i)
     ,.mem_resp_ready_and_i(mem_resp_ready_and_o)
     ,.errors_o(check_errors)
     ,.instrs_o(check_instrs)
     ,.cmds_o(check_cmds)
     ,.pending_o(check_pending)
     );

  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    return addr ^ mem_pattern_lp;
  endfunction

  // Handshakes seen mid-cycle complete at the next rising edge
  always @(negedge clk_i) begin
    cmd_taken     = mem_cmd_v_o & mem_cmd_ready_and_i;
    cmd_taken_hdr = mem_cmd_header_o;
    beat_taken    = mem_resp_v_i & mem_resp_ready_and_o;
    if (ready_mode == ready_random_lp) begin
      ready_next = 1'($urandom_range(1, 0));
    end else begin
      ready_next = (ready_mode == ready_high_lp);
    end
  end

  always @(posedge clk_i) begin
    #1;
    mem_cmd_ready_and_i = ready_next;
  end

  // Memory responder
  always @(posedge clk_i) begin
    #1;
    if (beat_taken) begin
      resp_beat++;
      if (resp_beat == resp_beats) begin
        resp_busy = 1'b0;
      end
    end
    if (cmd_taken) begin
      resp_busy  = 1'b1;
      resp_hdr   = cmd_taken_hdr;
      resp_delay = int'($urandom_range(5, 0));
      resp_beat  = 0;
      resp_beats = (cmd_taken_hdr.size == e_mem_size_16) ? 2 : 1;
    end
    mem_resp_v_i = 1'b0;
    if (resp_busy && (resp_delay > 0)) begin
      resp_delay--;
    end else if (resp_busy) begin
      beat_addr         = {resp_hdr.addr[31:3], 3'b000} + 32'(resp_beat * 8);
      mem_resp_header_i = resp_hdr;
      mem_resp_data_i   = {mem_word(beat_addr + 32'd4), mem_word(beat_addr)};
      mem_resp_last_i   = (resp_beat == resp_beats - 1);
      mem_resp_v_i      = 1'b1;
    end
  end

  task automatic print_summary();
    $display("Summary: %0d instructions checked, %0d memory commands checked, %0d errors",
             check_instrs, check_cmds, check_errors + stall_errors);
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    print_summary();
    $display("=== FAIL ===");
    $finish;
  endtask

  // Starts and returns 1 ns after a rising edge
  task automatic send_fetch(input vaddr_t vaddr, input ptag_t ptag, input logic uncached);
    int waited;
    waited               = 0;
    fetch_req_i.vaddr    = vaddr;
    fetch_req_i.ptag     = ptag;
    fetch_req_i.uncached = uncached;
    fetch_v_i            = 1'b1;
    @(negedge clk_i);
    while (!fetch_ready_o) begin
      waited++;
      if (waited > timeout_lp) begin
        abort_run("Timeout: a fetch request was never accepted");
      end
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #1;
    fetch_v_i = 1'b0;
  endtask

  task automatic send_random_fetch();
    vaddr_t vaddr;
    ptag_t  ptag;
    logic   uncached;
    // Few tags and sets so hits and evictions both happen
    vaddr    = {20'($urandom), 2'b00, 6'($urandom_range(3, 0)),
                2'($urandom_range(3, 0)), 2'b00};
    ptag     = 20'h50000 | 20'($urandom_range(3, 0));
    uncached = ($urandom_range(7, 0) == 0);
    send_fetch(vaddr, ptag, uncached);
  endtask

  task automatic fill_queue();
    int sent;
    sent        = 0;
    fetch_req_i = '{vaddr: 32'h0040_0400, ptag: 20'h40000, uncached: 1'b0};
    fetch_v_i   = 1'b1;
    @(negedge clk_i);
    while (fetch_ready_o) begin
      sent++;
      if (sent > 4 * queue_els_lp) begin
        abort_run("fetch_ready_o stayed high while memory commands were held off");
      end
      @(posedge clk_i);
      #1;
      fetch_req_i.vaddr = fetch_req_i.vaddr + 32'd16;
      fetch_req_i.ptag  = fetch_req_i.ptag + 20'd1;
      @(negedge clk_i);
    end
    // Every queue entry plus the misses held in TL and TV
    if (sent != queue_els_lp + 2) begin
      stall_errors++;
      $display("ERROR @ %0t: fetch_ready_o fell after %0d requests, expected %0d",
               $time, sent, queue_els_lp + 2);
    end
    @(posedge clk_i);
    #1;
    fetch_v_i = 1'b0;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    @(posedge clk_i);
    while (check_pending != 0) begin
      waited++;
      if (waited > timeout_lp) begin
        abort_run("Timeout: expected instructions or memory commands never arrived");
      end
      @(posedge clk_i);
    end
    #1;
  endtask

  initial begin
    reset_i     = 1'b1;
    fetch_req_i = '0;
    fetch_v_i   = 1'b0;
    ready_mode  = ready_high_lp;
    void'($urandom(76));
    repeat (5) @(posedge clk_i);
    #1;
    reset_i = 1'b0;

    // Cold miss followed by hits on the rest of the block
    for (int w = 0; w < 4; w++) begin
      send_fetch(32'h0040_0100 + 32'(w * 4), 20'h12345, 1'b0);
    end
    wait_drain();

    send_fetch(32'h0040_0200, 20'h22222, 1'b1);
    send_fetch(32'h0040_0204, 20'h22222, 1'b1);
    send_fetch(32'h0040_0208, 20'h22222, 1'b0);
    wait_drain();

    // A, B, A, C, B in set 0x30
    send_fetch(32'h0040_0300, 20'h31111, 1'b0);
    send_fetch(32'h0040_0304, 20'h32222, 1'b0);
    send_fetch(32'h0040_0308, 20'h31111, 1'b0);
    send_fetch(32'h0040_030c, 20'h33333, 1'b0);
    send_fetch(32'h0040_0300, 20'h32222, 1'b0);
    wait_drain();

    ready_mode = ready_low_lp;
    fill_queue();
    ready_mode = ready_random_lp;
    for (int i = 0; i < 60; i++) begin
      send_random_fetch();
    end
    wait_drain();

    print_summary();
    if ((check_errors + stall_errors) == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== test/icache_checker.sv ====
`timescale 1ns/1ps

module icache_checker
  import icache_pkg::*;
  import mem_pkg::*;
  #(parameter logic [31:0] pattern_p = 32'h5A5A0000)
  (input                 clk_i
   , input               reset_i

   , input fetch_req_s   fetch_req_i
   , input               fetch_v_i
   , input               fetch_ready_i

   , input instr_t       data_i
   , input               data_v_i

   , input mem_header_s  mem_cmd_header_i
   , input               mem_cmd_v_i
   , input               mem_cmd_ready_and_i
   , input               mem_resp_ready_and_i

   , output int          errors_o
   , output int          instrs_o
   , output int          cmds_o
   , output int          pending_o
   );

  typedef struct packed {
    logic        miss;
    mem_header_s cmd;
    instr_t      data;
  } expect_s;

  ptag_t       model_tag   [assoc_c][sets_c];
  logic        model_valid [assoc_c][sets_c];
  // Way to evict next
  logic        model_lru   [sets_c];
  instr_t      data_q [$];
  mem_header_s cmd_q [$];

  int          error_count   = 0;
  int          instr_count   = 0;
  int          cmd_count     = 0;
  int          pending_count = 0;
  logic        reset_seen    = 1'b0;
  expect_s     expected;
  instr_t      expected_data;
  mem_header_s expected_cmd;

  assign errors_o  = error_count;
  assign instrs_o  = instr_count;
  assign cmds_o    = cmd_count;
  assign pending_o = pending_count;

  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    return addr ^ pattern_p;
  endfunction

  // Sequential model of one fetch in acceptance order
  function automatic expect_s predict_fetch(input fetch_req_s req);
    expect_s result;
    paddr_t  paddr;
    index_t  idx;
    int      way;
    paddr       = {req.ptag, req.vaddr[page_offset_width_c-1:0]};
    idx         = req.vaddr[block_offset_width_c +: index_width_c];
    result.data = mem_word({paddr[31:2], 2'b00});
    result.miss = 1'b1;
    if (req.uncached) begin
      result.cmd = '{opcode: e_mem_rd_uncached, size: e_mem_size_4, addr: {paddr[31:2], 2'b00}};
    end else begin
      result.cmd = '{opcode: e_mem_rd_cached, size: e_mem_size_16, addr: {paddr[31:4], 4'h0}};
      way = -1;
      for (int w = 0; w < assoc_c; w++) begin
        if (model_valid[w][idx] && (model_tag[w][idx] == req.ptag)) begin
          way = w;
        end
      end
      if (way >= 0) begin
        result.miss = 1'b0;
      end else begin
        way = int'(model_lru[idx]);
        model_tag[way][idx]   = req.ptag;
        model_valid[way][idx] = 1'b1;
      end
      model_lru[idx] = (way == 0);
    end
    return result;
  endfunction

  always @(negedge clk_i) begin
    if (reset_i) begin
      for (int s = 0; s < sets_c; s++) begin
        model_lru[s] = 1'b0;
        for (int w = 0; w < assoc_c; w++) begin
          model_valid[w][s] = 1'b0;
        end
      end
      data_q.delete();
      cmd_q.delete();
      reset_seen = 1'b1;
    end else begin
      if (reset_seen) begin
        if (data_v_i || mem_cmd_v_i || !fetch_ready_i || !mem_resp_ready_and_i) begin
          error_count++;
          $display("ERROR @ %0t: after reset data_v=%b cmd_v=%b fetch_ready=%b resp_ready=%b",
                   $time, data_v_i, mem_cmd_v_i, fetch_ready_i, mem_resp_ready_and_i);
        end
        reset_seen = 1'b0;
      end
      if (fetch_v_i && fetch_ready_i) begin
        expected = predict_fetch(fetch_req_i);
        data_q.push_back(expected.data);
        if (expected.miss) begin
          cmd_q.push_back(expected.cmd);
        end
      end
      if (mem_cmd_v_i && mem_cmd_ready_and_i) begin
        if (cmd_q.size() == 0) begin
          error_count++;
          $display("ERROR @ %0t: memory command %h issued with none expected",
                   $time, mem_cmd_header_i);
        end else begin
          expected_cmd = cmd_q.pop_front();
          cmd_count++;
          if (mem_cmd_header_i !== expected_cmd) begin
            error_count++;
            $display("ERROR @ %0t: memory command %h, expected %h",
                     $time, mem_cmd_header_i, expected_cmd);
          end
        end
      end
      if (data_v_i) begin
        if (data_q.size() == 0) begin
          error_count++;
          $display("ERROR @ %0t: instruction %h returned with no fetch outstanding",
                   $time, data_i);
        end else begin
          expected_data = data_q.pop_front();
          instr_count++;
          if (data_i !== expected_data) begin
            error_count++;
            $display("ERROR @ %0t: instruction %h, expected %h", $time, data_i, expected_data);
          end
        end
      end
    end
    pending_count = data_q.size() + cmd_q.size();
  end

endmodule

// ==== src/icache_wrapper.sv ====
`timescale 1ns/1ps

module icache_wrapper
  import icache_pkg::*;
  import mem_pkg::*;
  #(parameter int fetch_queue_els_p = 8)
  (input                           clk_i
   , input                         reset_i

   , input fetch_req_s             fetch_req_i
   , input                         fetch_v_i
   , output logic                  fetch_ready_o

   , output instr_t                data_o
   , output logic                  data_v_o

   , output mem_header_s           mem_cmd_header_o
   , output logic                  mem_cmd_v_o
   , input                         mem_cmd_ready_and_i

   , input mem_header_s            mem_resp_header_i
   , input [mem_data_width_c-1:0]  mem_resp_data_i
   , input                         mem_resp_v_i
   , output logic                  mem_resp_ready_and_o
   , input                         mem_resp_last_i
   );

  fetch_req_s queue_req_lo;
  logic       queue_v_lo, cache_yumi_lo;
  cache_req_s miss_lo;
  logic       miss_v_lo, miss_ready_li;
  fill_pkt_s  fill_lo;
  logic       fill_v_lo, miss_done_lo;

  fetch_queue
   #(.els_p(fetch_queue_els_p))
   queue
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.req_i(fetch_req_i)
     ,.v_i(fetch_v_i)
     ,.ready_o(fetch_ready_o)
     ,.req_o(queue_req_lo)
     ,.v_o(queue_v_lo)
     ,.yumi_i(cache_yumi_lo)
     );

  icache
   cache
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.req_i(queue_req_lo)
     ,.req_v_i(queue_v_lo)
     ,.req_yumi_o(cache_yumi_lo)
     ,.data_o(data_o)
     ,.data_v_o(data_v_o)
     ,.miss_o(miss_lo)
     ,.miss_v_o(miss_v_lo)
     ,.miss_ready_i(miss_ready_li)
     ,.fill_i(fill_lo)
     ,.fill_v_i(fill_v_lo)
     ,.miss_done_i(miss_done_lo)
     );

  icache_miss_engine
   engine
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.miss_i(miss_lo)
     ,.miss_v_i(miss_v_lo)
     ,.miss_ready_o(miss_ready_li)
     ,.fill_o(fill_lo)
     ,.fill_v_o(fill_v_lo)
     ,.miss_done_o(miss_done_lo)
     ,.mem_cmd_header_o(mem_cmd_header_o)
     ,.mem_cmd_v_o(mem_cmd_v_o)
     ,.mem_cmd_ready_and_i(mem_cmd_ready_and_i)
     ,.mem_resp_header_i(mem_resp_header_i)
     ,.mem_resp_data_i(mem_resp_data_i)
     ,.mem_resp_v_i(mem_resp_v_i)
     ,.mem_resp_ready_and_o(mem_resp_ready_and_o)
     ,.mem_resp_last_i(mem_resp_last_i)
     );

endmodule

// ==== src/icache_miss_engine.sv ====
`timescale 1ns/1ps

module icache_miss_engine
  import icache_pkg::*;
  import mem_pkg::*;
  (input                           clk_i
   , input                         reset_i

   , input cache_req_s             miss_i
   , input                         miss_v_i
   , output logic                  miss_ready_o

   , output fill_pkt_s             fill_o
   , output logic                  fill_v_o
   , output logic                  miss_done_o

   , output mem_header_s           mem_cmd_header_o
   , output logic                  mem_cmd_v_o
   , input                         mem_cmd_ready_and_i

   , input mem_header_s            mem_resp_header_i
   , input [mem_data_width_c-1:0]  mem_resp_data_i
   , input                         mem_resp_v_i
   , output logic                  mem_resp_ready_and_o
   , input                         mem_resp_last_i
   );

  localparam paddr_t block_mask_lp = ~paddr_t'((1 << block_offset_width_c) - 1);
  localparam paddr_t word_mask_lp  = ~paddr_t'((instr_width_c / 8) - 1);

  typedef enum logic [1:0] {
    e_idle,
    e_send,
    e_wait,
    e_done
  } state_e;

  state_e     state_r, state_n;
  cache_req_s req_r;
  beat_t      beat_r;
  logic       resp_uncached;

  assign miss_ready_o = (state_r == e_idle);
  assign mem_cmd_v_o  = (state_r == e_send);
  assign miss_done_o  = (state_r == e_done);

  // Fills are always accepted by the cache
  assign mem_resp_ready_and_o = 1'b1;

  always_comb begin
    if (req_r.uncached) begin
      mem_cmd_header_o.opcode = e_mem_rd_uncached;
      mem_cmd_header_o.size   = e_mem_size_4;
      mem_cmd_header_o.addr   = req_r.paddr & word_mask_lp;
    end else begin
      mem_cmd_header_o.opcode = e_mem_rd_cached;
      mem_cmd_header_o.size   = e_mem_size_16;
      mem_cmd_header_o.addr   = req_r.paddr & block_mask_lp;
    end
  end

  assign resp_uncached = (mem_resp_header_i.opcode == e_mem_rd_uncached);

  always_comb begin
    fill_o.kind  = resp_uncached ? e_fill_uncached : e_fill_data;
    fill_o.index = req_r.paddr[block_offset_width_c +: index_width_c];
    fill_o.way   = req_r.way;
    fill_o.beat  = beat_r;
    fill_o.tag   = req_r.paddr[page_offset_width_c +: ptag_width_c];
    fill_o.data  = mem_resp_data_i;
    fill_v_o     = 1'b0;
    if (state_r == e_wait) begin
      fill_v_o = mem_resp_v_i;
    end else if ((state_r == e_done) && !req_r.uncached) begin
      // Tag goes in once the whole block is written
      fill_o.kind = e_fill_tag;
      fill_v_o    = 1'b1;
    end
  end

  always_comb begin
    state_n = state_r;
    case (state_r)
      e_idle: if (miss_v_i) state_n = e_send;
      e_send: if (mem_cmd_ready_and_i) state_n = e_wait;
      e_wait: if (mem_resp_v_i && mem_resp_last_i) state_n = e_done;
      default: state_n = e_idle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= e_idle;
      beat_r  <= '0;
    end else begin
      state_r <= state_n;
      if (state_r == e_idle) begin
        beat_r <= '0;
      end else if ((state_r == e_wait) && mem_resp_v_i) begin
        beat_r <= beat_r + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (miss_ready_o && miss_v_i) begin
      req_r <= miss_i;
    end
  end

endmodule

// ==== src/icache.sv ====
`timescale 1ns/1ps

module icache
  import icache_pkg::*;
  import mem_pkg::*;
  (input                clk_i
   , input              reset_i

   , input fetch_req_s  req_i
   , input              req_v_i
   , output logic       req_yumi_o

   , output instr_t     data_o
   , output logic       data_v_o

   , output cache_req_s miss_o
   , output logic       miss_v_o
   , input              miss_ready_i

   , input fill_pkt_s   fill_i
   , input              fill_v_i
   , input              miss_done_i
   );

  localparam int byte_sel_width_lp = $clog2(instr_width_c / 8);
  localparam int word_sel_width_lp = $clog2(block_width_c / instr_width_c);
  localparam int lane_sel_width_lp = $clog2(mem_data_width_c / instr_width_c);

  ptag_t                          tag_mem  [assoc_c][sets_c];
  logic [block_width_c-1:0]       data_mem [assoc_c][sets_c];
  logic [assoc_c-1:0][sets_c-1:0] valid_r;
  // Points at the way to evict next
  logic [sets_c-1:0]              lru_r;

  ptag_t                    tag_rd_r  [assoc_c];
  logic [block_width_c-1:0] data_rd_r [assoc_c];
  logic [assoc_c-1:0]       valid_rd_r;

  logic       tl_v_r, tv_v_r;
  fetch_req_s tl_req_r, tv_req_r;
  logic       miss_sent_r, replay_r, unc_ret_r;
  instr_t     unc_word_r;

  index_t                       tl_index, tv_index, rd_index;
  logic                         advance, tl_ready, rd_en;
  logic                         hit, hit_out;
  way_t                         hit_way;
  logic [block_width_c-1:0]     hit_block;
  logic [word_sel_width_lp-1:0] word_sel;
  logic [lane_sel_width_lp-1:0] lane_sel;

  assign tl_index = tl_req_r.vaddr[block_offset_width_c +: index_width_c];
  assign tv_index = tv_req_r.vaddr[block_offset_width_c +: index_width_c];
  assign word_sel = tv_req_r.vaddr[byte_sel_width_lp +: word_sel_width_lp];
  // Uncached word sits in its own lane of the aligned memory beat
  assign lane_sel = tv_req_r.vaddr[byte_sel_width_lp +: lane_sel_width_lp];

  // TV tag compare
  always_comb begin
    hit     = 1'b0;
    hit_way = '0;
    for (int w = 0; w < assoc_c; w++) begin
      if (valid_rd_r[w] && (tag_rd_r[w] == tv_req_r.ptag)) begin
        hit     = 1'b1;
        hit_way = way_t'(w);
      end
    end
  end

  assign hit_block = data_rd_r[hit_way];
  assign hit_out   = tv_v_r & ~tv_req_r.uncached & hit;
  assign data_v_o  = hit_out | unc_ret_r;
  assign data_o    = unc_ret_r ? unc_word_r
                               : hit_block[word_sel*instr_width_c +: instr_width_c];

  // TV retires, so TL may move up
  assign advance    = ~tv_v_r | data_v_o;
  assign tl_ready   = ~tl_v_r | advance;
  assign req_yumi_o = req_v_i & tl_ready;

  // Replay re-reads the TV set after a fill
  assign rd_en    = replay_r | advance;
  assign rd_index = replay_r ? tv_index : tl_index;

  assign miss_o.paddr    = {tv_req_r.ptag, tv_req_r.vaddr[page_offset_width_c-1:0]};
  assign miss_o.uncached = tv_req_r.uncached;
  assign miss_o.way      = way_t'(lru_r[tv_index]);
  assign miss_v_o        = tv_v_r & ~miss_sent_r & ~replay_r & ~unc_ret_r
                           & (tv_req_r.uncached | ~hit);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      tl_v_r      <= 1'b0;
      tv_v_r      <= 1'b0;
      miss_sent_r <= 1'b0;
      replay_r    <= 1'b0;
      unc_ret_r   <= 1'b0;
      valid_r     <= '0;
      lru_r       <= '0;
    end else begin
      if (tl_ready) begin
        tl_v_r <= req_v_i;
      end
      if (advance) begin
        tv_v_r <= tl_v_r;
      end
      if (miss_v_o && miss_ready_i) begin
        miss_sent_r <= 1'b1;
      end else if (miss_done_i) begin
        miss_sent_r <= 1'b0;
      end
      replay_r  <= miss_done_i & ~tv_req_r.uncached;
      unc_ret_r <= miss_done_i & tv_req_r.uncached;
      if (fill_v_i && (fill_i.kind == e_fill_tag)) begin
        valid_r[fill_i.way][fill_i.index] <= 1'b1;
      end
      if (hit_out) begin
        lru_r[tv_index] <= ~hit_way;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (tl_ready) begin
      tl_req_r <= req_i;
    end
    if (advance) begin
      tv_req_r <= tl_req_r;
    end
    if (rd_en) begin
      for (int w = 0; w < assoc_c; w++) begin
        tag_rd_r[w]   <= tag_mem[w][rd_index];
        data_rd_r[w]  <= data_mem[w][rd_index];
        valid_rd_r[w] <= valid_r[w][rd_index];
      end
    end
  end

  // Fills are written in the cycle they arrive
  always_ff @(posedge clk_i) begin
    if (fill_v_i) begin
      case (fill_i.kind)
        e_fill_data: begin
          data_mem[fill_i.way][fill_i.index][fill_i.beat*fill_width_c +: fill_width_c]
            <= fill_i.data;
        end
        e_fill_tag: begin
          tag_mem[fill_i.way][fill_i.index] <= fill_i.tag;
        end
        default: begin
          unc_word_r <= fill_i.data[lane_sel*instr_width_c +: instr_width_c];
        end
      endcase
    end
  end

endmodule

// ==== src/fetch_queue.sv ====
`timescale 1ns/1ps

module fetch_queue
  import icache_pkg::*;
  #(parameter int els_p = 8)
  (input                clk_i
   , input              reset_i

   , input fetch_req_s  req_i
   , input              v_i
   , output logic       ready_o

   , output fetch_req_s req_o
   , output logic       v_o
   , input              yumi_i
   );

  localparam int ptr_width_lp = $clog2(els_p);

  fetch_req_s            mem_r [els_p];
  logic [ptr_width_lp:0] wr_ptr_r, rd_ptr_r;
  logic                  enq, empty, full;

  // Top pointer bit is the wrap bit
  assign empty = (wr_ptr_r == rd_ptr_r);
  assign full  = (wr_ptr_r[ptr_width_lp] != rd_ptr_r[ptr_width_lp])
                 && (wr_ptr_r[ptr_width_lp-1:0] == rd_ptr_r[ptr_width_lp-1:0]);

  assign ready_o = ~full;
  assign v_o     = ~empty;
  assign req_o   = mem_r[rd_ptr_r[ptr_width_lp-1:0]];
  assign enq     = v_i & ~full;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
    end else begin
      if (enq) begin
        wr_ptr_r <= wr_ptr_r + 1'b1;
      end
      if (yumi_i) begin
        rd_ptr_r <= rd_ptr_r + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (enq) begin
      mem_r[wr_ptr_r[ptr_width_lp-1:0]] <= req_i;
    end
  end

endmodule

// ==== src/mem_pkg.sv ====
package mem_pkg;

  localparam int mem_data_width_c = 64;
  localparam int mem_addr_width_c = 32;

  typedef enum logic [1:0] {
    e_mem_rd_cached   = 2'd0,
    e_mem_rd_uncached = 2'd1
  } mem_opcode_e;

  // Encoded as log2 of the byte count minus 2
  typedef enum logic [1:0] {
    e_mem_size_4  = 2'd0,
    e_mem_size_16 = 2'd2
  } mem_size_e;

  typedef struct packed {
    mem_opcode_e                 opcode;
    mem_size_e                   size;
    logic [mem_addr_width_c-1:0] addr;
  } mem_header_s;

endpackage

// ==== src/icache_pkg.sv ====
package icache_pkg;

  // Cache geometry
  localparam int vaddr_width_c        = 32;
  localparam int ptag_width_c         = 20;
  localparam int page_offset_width_c  = 12;
  localparam int sets_c               = 64;
  localparam int assoc_c              = 2;
  localparam int index_width_c        = 6;
  localparam int block_offset_width_c = 4;
  localparam int block_width_c        = 128;
  localparam int fill_width_c         = 64;
  localparam int fill_beats_c         = 2;
  localparam int instr_width_c        = 32;

  typedef logic [vaddr_width_c-1:0]                    vaddr_t;
  typedef logic [ptag_width_c-1:0]                     ptag_t;
  typedef logic [instr_width_c-1:0]                    instr_t;
  typedef logic [ptag_width_c+page_offset_width_c-1:0] paddr_t;
  typedef logic [$clog2(assoc_c)-1:0]                  way_t;
  typedef logic [index_width_c-1:0]                    index_t;
  typedef logic [$clog2(fill_beats_c)-1:0]             beat_t;

  typedef enum logic [1:0] {
    e_fill_data     = 2'd0,
    e_fill_tag      = 2'd1,
    e_fill_uncached = 2'd2
  } fill_kind_e;

  typedef struct packed {
    vaddr_t vaddr;
    ptag_t  ptag;
    logic   uncached;
  } fetch_req_s;

  typedef struct packed {
    paddr_t paddr;
    logic   uncached;
    way_t   way;
  } cache_req_s;

  typedef struct packed {
    fill_kind_e               kind;
    index_t                   index;
    way_t                     way;
    beat_t                    beat;
    ptag_t                    tag;
    logic [fill_width_c-1:0]  data;
  } fill_pkt_s;

endpackage
